// ==== include/memWrap_params.svh ====
// Address map of the load/store subsystem
// Data memory geometry and control-register byte offsets
`ifndef MEMWRAP_PARAMS_SVH
`define MEMWRAP_PARAMS_SVH

// --------------------
// Data memory region
// --------------------
// Byte address of the first data word
`define DMEM_BASE    32'h0001_0000
// Depth in 32-bit words
`define DMEM_WORDS   4096
// Word index width, taken from address bits 13:2
`define DMEM_ADDR_W  12

// --------------------
// Control registers
// --------------------
// Byte address of the register block
`define CR_BASE      32'h0002_0000
// Byte span of the register block
`define CR_SIZE      32'h0000_0100

// Register byte offsets inside the block
`define CR_LED       8'h00
`define CR_SEG       8'h04
`define CR_SWITCH    8'h08
`define CR_BUTTON    8'h0C
`define CR_SCRATCH   8'h10

`endif

// ==== design/memWrapPkg.sv ====
// Shared types of the load/store subsystem
// Core request and response, board inputs and board outputs
package memWrapPkg;

   // --------------------
   // Core side
   // --------------------

   // One data request per clock
   typedef struct packed {
      logic        valid;
      logic        wrEn;
      logic        rdEn;
      // Byte address
      logic [31:0] address;
      // Store data, low lanes hold the value
      logic [31:0] wrData;
      // One bit per byte lane, before alignment
      logic [3:0]  byteEn;
   } t_memReq;

   // Read result, one cycle after the request
   typedef struct packed {
      logic        valid;
      logic [31:0] rdData;
   } t_memRsp;

   // --------------------
   // Board side
   // --------------------

   // Raw board inputs, asynchronous to Clk
   typedef struct packed {
      logic       button0;
      logic       button1;
      logic [9:0] switch;
   } t_fpgaIn;

   // Board outputs
   typedef struct packed {
      logic [9:0]  leds;
      // Six hex digits, digit 0 in the low nibble
      logic [23:0] segValue;
   } t_fpgaOut;

endpackage

// ==== design/dataMem.sv ====
// Data memory of the load/store subsystem
// Synchronous byte-enabled RAM, one read port and one write port
// Store lane alignment and load realignment for sub-word accesses
`timescale 1ns/10ps
`include "memWrap_params.svh"

module dataMem (
   input  logic                Clk,
   // Request already qualified by the region decode
   input  memWrapPkg::t_memReq req,
   // Read data, one cycle after the request
   output logic [31:0]         q
);
   import memWrapPkg::*;

   // Word storage, contents are not reset
   logic [31:0] mem [0:`DMEM_WORDS-1];

   // Word index from address bits 13:2
   logic [`DMEM_ADDR_W-1:0] wordIdx;

   // Request with data and enables moved to their byte lanes
   t_memReq alignedReq;

   // Raw word and byte offset held for the realignment
   logic [31:0] rdWordQ104H;
   logic [1:0]  offsetQ104H;

   // Qualified strobes
   logic wrStrobe;
   logic rdStrobe;

   assign wordIdx  = req.address[`DMEM_ADDR_W+1:2];
   assign wrStrobe = req.valid && req.wrEn;
   assign rdStrobe = req.valid && req.rdEn;

   // --------------------
   // Store alignment
   // --------------------
   // Data moves up by 8 bits per byte of offset
   // Enables move up by one lane per byte of offset
   // Anything pushed past lane 3 is lost
   always_comb begin
      alignedReq        = req;
      alignedReq.wrData = req.wrData << {req.address[1:0], 3'b000};
      alignedReq.byteEn = req.byteEn << req.address[1:0];
   end

   // --------------------
   // RAM array
   // --------------------
   // Only enabled lanes are written
   always_ff @(posedge Clk) begin
      if (wrStrobe) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (alignedReq.byteEn[lane]) begin
               mem[wordIdx][lane*8 +: 8] <= alignedReq.wrData[lane*8 +: 8];
            end
         end
      end
   end

   // Synchronous read
   // Same-edge write is not seen here, old word comes back
   always_ff @(posedge Clk) begin
      if (rdStrobe) begin
         rdWordQ104H <= mem[wordIdx];
         offsetQ104H <= req.address[1:0];
      end
   end

   // --------------------
   // Load realignment
   // --------------------
   // Addressed byte lands in lane 0, upper bytes zero-filled
   // Sign or zero extension is left to the core
   assign q = rdWordQ104H >> {offsetQ104H, 3'b000};

endmodule

// ==== design/crMem.sv ====
// Control register block of the load/store subsystem
// LED, seven-segment and scratch registers, written as whole words
// Switch and button inputs through two-flop synchronizers
// Registered read mux, one cycle of latency
`timescale 1ns/10ps
`include "memWrap_params.svh"

module crMem (
   input  logic                 Clk,
   input  logic                 rstN,
   // Request already qualified by the region decode
   input  memWrapPkg::t_memReq  req,
   // Read data, one cycle after the request
   output logic [31:0]          q,
   // Board side
   input  memWrapPkg::t_fpgaIn  fpgaIn,
   output memWrapPkg::t_fpgaOut fpgaOut
);
   import memWrapPkg::*;

   // Byte offset inside the register block
   logic [7:0] offset;

   // Writable registers, stored at their field widths
   logic [9:0]  ledQ;
   logic [23:0] segQ;
   logic [31:0] scratchQ;

   // Synchronizer stages
   t_fpgaIn fpgaInMeta;
   t_fpgaIn fpgaInSync;

   // Read value before the output flop
   logic [31:0] rdDataNext;

   assign offset = req.address[7:0];

   // --------------------
   // Input synchronizers
   // --------------------
   // Two flops per bit, whole struct moves together
   always_ff @(posedge Clk) begin
      if (!rstN) begin
         fpgaInMeta <= '0;
         fpgaInSync <= '0;
      end else begin
         fpgaInMeta <= fpgaIn;
         fpgaInSync <= fpgaInMeta;
      end
   end

   // --------------------
   // Register writes
   // --------------------
   // Byte enables play no part here
   // Switch, button and unknown offsets drop the write
   always_ff @(posedge Clk) begin
      if (!rstN) begin
         ledQ     <= '0;
         segQ     <= '0;
         scratchQ <= '0;
      end else if (req.valid && req.wrEn) begin
         case (offset)
            `CR_LED:     ledQ     <= req.wrData[9:0];
            `CR_SEG:     segQ     <= req.wrData[23:0];
            `CR_SCRATCH: scratchQ <= req.wrData;
            default:     ;
         endcase
      end
   end

   // --------------------
   // Register reads
   // --------------------
   // Unknown offsets read as zero
   always_comb begin
      case (offset)
         `CR_LED:     rdDataNext = {22'b0, ledQ};
         `CR_SEG:     rdDataNext = {8'b0, segQ};
         `CR_SWITCH:  rdDataNext = {22'b0, fpgaInSync.switch};
         // Bit 0 is button0, bit 1 is button1
         `CR_BUTTON:  rdDataNext = {30'b0, fpgaInSync.button1, fpgaInSync.button0};
         `CR_SCRATCH: rdDataNext = scratchQ;
         default:     rdDataNext = '0;
      endcase
   end

   // Output flop, old value on a combined write and read
   always_ff @(posedge Clk) begin
      if (req.valid && req.rdEn) begin
         q <= rdDataNext;
      end
   end

   // Board outputs straight from the registers
   assign fpgaOut.leds     = ledQ;
   assign fpgaOut.segValue = segQ;

endmodule

// ==== design/memWrap.sv ====
// Top of the load/store memory subsystem
// Region decode of each core request: data memory, control registers, unmapped
// Request steering to dataMem and crMem
// Delayed region select and read response mux
`timescale 1ns/10ps
`include "memWrap_params.svh"

module memWrap (
   input  logic                 Clk,
   input  logic                 rstN,
   // Core data port
   input  memWrapPkg::t_memReq  req,
   output memWrapPkg::t_memRsp  rsp,
   // Board I/O
   input  memWrapPkg::t_fpgaIn  fpgaIn,
   output memWrapPkg::t_fpgaOut fpgaOut
);
   import memWrapPkg::*;

   // First byte past each region
   localparam logic [31:0] dmemLimit = `DMEM_BASE + 4 * `DMEM_WORDS;
   localparam logic [31:0] crLimit   = `CR_BASE + `CR_SIZE;

   // --------------------
   // Signals
   // --------------------
   // Region hits at the request stage
   logic dmemHitQ103H;
   logic crHitQ103H;

   // Read request at the request stage
   logic rdReqQ103H;

   // Same flags one cycle later, at the response stage
   logic dmemHitQ104H;
   logic crHitQ104H;
   logic rdReqQ104H;

   // Requests qualified per region
   t_memReq dmemReq;
   t_memReq crReq;

   // Read data of each block, response stage
   logic [31:0] dmemRdDataQ104H;
   logic [31:0] crRdDataQ104H;

   // Selected read data
   logic [31:0] rdDataQ104H;

   // --------------------
   // Region decode
   // --------------------
   // Half-open ranges, base included and limit excluded
   // Regions do not overlap, so at most one hit
   always_comb begin
      dmemHitQ103H = (req.address >= `DMEM_BASE) && (req.address < dmemLimit);
      crHitQ103H   = (req.address >= `CR_BASE)   && (req.address < crLimit);
   end

   assign rdReqQ103H = req.valid && req.rdEn;

   // --------------------
   // Request steering
   // --------------------
   // Every field passes through, only valid is qualified
   // Unmapped requests reach no block, so writes there do nothing
   always_comb begin
      dmemReq       = req;
      dmemReq.valid = req.valid && dmemHitQ103H;
      crReq         = req;
      crReq.valid   = req.valid && crHitQ103H;
   end

   // --------------------
   // Q103H to Q104H flops
   // --------------------
   // Hit flags follow the address every cycle
   // Response mux only looks at them when rdReqQ104H is set
   always_ff @(posedge Clk) begin
      if (!rstN) begin
         dmemHitQ104H <= 1'b0;
         crHitQ104H   <= 1'b0;
         rdReqQ104H   <= 1'b0;
      end else begin
         dmemHitQ104H <= dmemHitQ103H;
         crHitQ104H   <= crHitQ103H;
         rdReqQ104H   <= rdReqQ103H;
      end
   end

   // --------------------
   // Blocks
   // --------------------
   // Data RAM, no reset on the array
   dataMem u_dataMem (
      .Clk (Clk),
      .req (dmemReq),
      .q   (dmemRdDataQ104H)
   );

   // Control registers and board I/O
   crMem u_crMem (
      .Clk     (Clk),
      .rstN    (rstN),
      .req     (crReq),
      .q       (crRdDataQ104H),
      .fpgaIn  (fpgaIn),
      .fpgaOut (fpgaOut)
   );

   // --------------------
   // Response
   // --------------------
   // Region that was hit a cycle ago picks the data
   // Unmapped reads return zero
   always_comb begin
      if (crHitQ104H) begin
         rdDataQ104H = crRdDataQ104H;
      end else if (dmemHitQ104H) begin
         rdDataQ104H = dmemRdDataQ104H;
      end else begin
         rdDataQ104H = '0;
      end
   end

   // Fixed latency of one, writes give no response
   always_comb begin
      rsp.valid  = rdReqQ104H;
      rsp.rdData = rdDataQ104H;
   end

endmodule

// ==== bench/memWrapTb.sv ====
// Testbench of the load/store memory subsystem
// Clock, reset and bus stimulus, byte-level data memory model
// Shadow control registers and concurrent response checks
`timescale 1ns/10ps
`include "memWrap_params.svh"

module memWrapTb;
   import memWrapPkg::*;

   // Polls allowed before a board input change counts as lost
   localparam int PollLimit = 3;
   localparam int WordCount = 16;

   logic     Clk;
   logic     rstN;
   t_memReq  req;
   t_memRsp  rsp;
   t_fpgaIn  fpgaIn;
   t_fpgaOut fpgaOut;

   int seed;
   int cycleCount;

   // Expectation for the request now on the bus
   logic        expCheck;
   logic [31:0] expData;
   // Same expectation at the response stage
   logic        expValidQ;
   logic        expCheckQ;
   logic [31:0] expDataQ;

   // Register shadows
   // expOutQ lags by the write latency
   t_fpgaOut    shadowOut;
   t_fpgaOut    expOutQ;
   logic [31:0] shadowScratch;

   // Byte image of the data memory
   logic [7:0]  dmemModel [0:4*`DMEM_WORDS-1];
   logic [31:0] wordAddr [0:WordCount-1];

   memWrap u_dut (
      .Clk     (Clk),
      .rstN    (rstN),
      .req     (req),
      .rsp     (rsp),
      .fpgaIn  (fpgaIn),
      .fpgaOut (fpgaOut)
   );

   always #4 Clk = ~Clk;

   // --------------------
   // Expectation pipeline
   // --------------------
   // Read response due one cycle after each read request
   always @(posedge Clk) begin
      cycleCount <= cycleCount + 1;
      if (!rstN) begin
         expValidQ <= 1'b0;
         expCheckQ <= 1'b0;
         expOutQ   <= '0;
      end else begin
         expValidQ <= req.valid && req.rdEn;
         expCheckQ <= expCheck;
         expOutQ   <= shadowOut;
      end
      expDataQ <= expData;
   end

   task automatic stopWithFailure();
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // --------------------
   // Checks
   // --------------------
   // Flops hold no defined value before the first edge
   resetStateCheck: assert property (@(posedge Clk)
      (cycleCount == 0) || rstN || (!rsp.valid && (fpgaOut == '0)))
      else begin
         $display("FAILED at %0d ns: reset state rsp.valid/fpgaOut expected 0/%h actual %b/%h",
                  $time, 34'h0, $sampled(rsp.valid), $sampled(fpgaOut));
         stopWithFailure();
      end

   rspValidCheck: assert property (@(posedge Clk)
      (cycleCount == 0) || (rsp.valid == expValidQ))
      else begin
         $display("FAILED at %0d ns: rsp.valid expected %b actual %b",
                  $time, $sampled(expValidQ), $sampled(rsp.valid));
         stopWithFailure();
      end

   rspDataCheck: assert property (@(posedge Clk)
      (cycleCount == 0) || !expCheckQ || (rsp.rdData == expDataQ))
      else begin
         $display("FAILED at %0d ns: rsp.rdData expected %h actual %h",
                  $time, $sampled(expDataQ), $sampled(rsp.rdData));
         stopWithFailure();
      end

   // Register writes reach the board one cycle after the request edge
   fpgaOutCheck: assert property (@(posedge Clk)
      (cycleCount == 0) || (fpgaOut == expOutQ))
      else begin
         $display("FAILED at %0d ns: fpgaOut expected %h actual %h",
                  $time, $sampled(expOutQ), $sampled(fpgaOut));
         stopWithFailure();
      end

   // --------------------
   // Reference model
   // --------------------
   // Word at the address moved down by the byte offset and zero-filled
   function automatic logic [31:0] modelWord(input logic [31:0] addr);
      logic [31:0] word;
      word = {dmemModel[{addr[13:2], 2'd3}], dmemModel[{addr[13:2], 2'd2}],
              dmemModel[{addr[13:2], 2'd1}], dmemModel[{addr[13:2], 2'd0}]};
      return word >> {addr[1:0], 3'b000};
   endfunction

   // Data and enables move up by the offset
   // Lanes pushed past lane 3 are lost
   function automatic void applyStore(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [3:0] be);
      logic [31:0] laneData;
      logic [3:0]  laneEn;
      logic [2:0]  lane;
      laneData = data << {addr[1:0], 3'b000};
      laneEn   = be << addr[1:0];
      for (lane = 3'd0; lane < 3'd4; lane = lane + 3'd1) begin
         if (laneEn[0]) begin
            dmemModel[{addr[13:2], lane[1:0]}] = laneData[7:0];
         end
         laneEn   = laneEn >> 1;
         laneData = laneData >> 8;
      end
   endfunction

   function automatic logic [31:0] crExpect(input logic [7:0] off);
      case (off)
         `CR_LED:     return {22'b0, shadowOut.leds};
         `CR_SEG:     return {8'b0, shadowOut.segValue};
         `CR_SWITCH:  return {22'b0, fpgaIn.switch};
         `CR_BUTTON:  return {30'b0, fpgaIn.button1, fpgaIn.button0};
         `CR_SCRATCH: return shadowScratch;
         default:     return 32'h0;
      endcase
   endfunction

   // --------------------
   // Bus drivers
   // --------------------
   // One request held for one cycle from 1 ns after the edge
   task automatic issueReq(input logic wr, input logic rd, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] be,
                           input logic check, input logic [31:0] want);
      @(posedge Clk);
      #1;
      req.valid   = 1'b1;
      req.wrEn    = wr;
      req.rdEn    = rd;
      req.address = addr;
      req.wrData  = data;
      req.byteEn  = be;
      expCheck    = check && rd;
      expData     = want;
   endtask

   task automatic idleCycle();
      @(posedge Clk);
      #1;
      req      = '0;
      expCheck = 1'b0;
      expData  = '0;
   endtask

   task automatic storeData(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
      issueReq(1'b1, 1'b0, addr, data, be, 1'b0, 32'h0);
      applyStore(addr, data, be);
   endtask

   task automatic loadData(input logic [31:0] addr);
      issueReq(1'b0, 1'b1, addr, 32'h0, 4'h0, 1'b1, modelWord(addr));
   endtask

   // Write and read together return the old word
   task automatic swapData(input logic [31:0] addr, input logic [31:0] data);
      issueReq(1'b1, 1'b1, addr, data, 4'hF, 1'b1, modelWord(addr));
      applyStore(addr, data, 4'hF);
   endtask

   // Whole-word register write
   // Byte enables have no effect in the block
   task automatic crStore(input logic [7:0] off, input logic [31:0] data,
                          input logic [3:0] be);
      issueReq(1'b1, 1'b0, `CR_BASE + {24'b0, off}, data, be, 1'b0, 32'h0);
      case (off)
         `CR_LED:     shadowOut.leds = data[9:0];
         `CR_SEG:     shadowOut.segValue = data[23:0];
         `CR_SCRATCH: shadowScratch = data;
         default:     ;
      endcase
   endtask

   task automatic crLoad(input logic [7:0] off);
      issueReq(1'b0, 1'b1, `CR_BASE + {24'b0, off}, 32'h0, 4'h0, 1'b1, crExpect(off));
   endtask

   task automatic applyInputs(input t_fpgaIn value);
      @(posedge Clk);
      #1;
      fpgaIn   = value;
      req      = '0;
      expCheck = 1'b0;
   endtask

   // Back-to-back unchecked reads until the register shows the value
   task automatic pollInput(input logic [7:0] off, input logic [31:0] want);
      int   tries;
      logic seen;
      tries = 0;
      seen  = 1'b0;
      issueReq(1'b0, 1'b1, `CR_BASE + {24'b0, off}, 32'h0, 4'h0, 1'b0, 32'h0);
      while (!seen) begin
         if (tries >= PollLimit) begin
            $display("Timeout: register at offset %h did not show %h within %0d cycles",
                     off, want, PollLimit);
            stopWithFailure();
         end else begin
            issueReq(1'b0, 1'b1, `CR_BASE + {24'b0, off}, 32'h0, 4'h0, 1'b0, 32'h0);
            // Response of the previous poll is on rsp now
            if (rsp.valid && (rsp.rdData == want)) begin
               seen = 1'b1;
            end
            tries++;
         end
      end
      idleCycle();
   endtask

   // --------------------
   // Stimulus
   // --------------------
   initial begin
      logic [31:0] addr;
      logic [31:0] holes [0:4];
      t_fpgaIn     inVal;
      int          i;
      seed          = 16521;
      cycleCount    = 0;
      Clk           = 1'b0;
      rstN          = 1'b0;
      req           = '0;
      fpgaIn        = '0;
      expCheck      = 1'b0;
      expData       = '0;
      shadowOut     = '0;
      shadowScratch = '0;
      repeat (2) @(posedge Clk);
      #1;
      rstN = 1'b1;
      idleCycle();

      // Random full words followed by back-to-back reads
      for (i = 0; i < WordCount; i++) begin
         wordAddr[i] = `DMEM_BASE + {18'b0, 12'($random(seed)), 2'b00};
         storeData(wordAddr[i], $random(seed), 4'hF);
      end
      for (i = 0; i < WordCount; i++) begin
         loadData(wordAddr[i]);
      end
      // Read right after a write and a combined write and read
      storeData(wordAddr[0], $random(seed), 4'hF);
      loadData(wordAddr[0]);
      swapData(wordAddr[1], $random(seed));
      loadData(wordAddr[1]);
      idleCycle();

      // Bytes and halves at every offset of the top word
      addr = `DMEM_BASE + 4 * `DMEM_WORDS - 4;
      storeData(addr, $random(seed), 4'hF);
      for (i = 1; i < 4; i++) begin
         storeData(addr + i, $random(seed), 4'h1);
         loadData(addr + i);
      end
      for (i = 1; i < 4; i++) begin
         storeData(addr + i, $random(seed), 4'h3);
         loadData(addr + i);
         loadData(addr);
      end
      idleCycle();

      // Register writes with truncation, read-only and unknown offsets
      crStore(`CR_LED, 32'hFFFF_F2A5, 4'h1);
      crStore(`CR_SEG, 32'hAB12_3456, 4'h0);
      crStore(`CR_SCRATCH, $random(seed), 4'hF);
      crStore(`CR_SWITCH, 32'h0000_03FF, 4'hF);
      crStore(`CR_BUTTON, 32'h0000_0003, 4'hF);
      crStore(8'h14, 32'hDEAD_BEEF, 4'hF);
      crLoad(`CR_LED);
      crLoad(`CR_SEG);
      crLoad(`CR_SCRATCH);
      crLoad(`CR_SWITCH);
      crLoad(`CR_BUTTON);
      crLoad(8'h14);
      idleCycle();

      // Board inputs through the synchronizer
      inVal        = '0;
      inVal.switch = 10'($random(seed));
      applyInputs(inVal);
      pollInput(`CR_SWITCH, {22'b0, inVal.switch});
      crLoad(`CR_SWITCH);
      for (i = 1; i < 4; i++) begin
         inVal.button0 = i[0];
         inVal.button1 = i[1];
         applyInputs(inVal);
         pollInput(`CR_BUTTON, {30'b0, inVal.button1, inVal.button0});
         crLoad(`CR_BUTTON);
      end
      idleCycle();

      // Unmapped holes
      // The first two alias DMEM word 0 and the LED register
      storeData(`DMEM_BASE, $random(seed), 4'hF);
      holes[0] = `DMEM_BASE + 4 * `DMEM_WORDS;
      holes[1] = `CR_BASE + `CR_SIZE;
      holes[2] = `DMEM_BASE - 4;
      holes[3] = `CR_BASE - 4;
      holes[4] = 32'h0000_0040;
      for (i = 0; i < 5; i++) begin
         issueReq(1'b1, 1'b0, holes[i], $random(seed), 4'hF, 1'b0, 32'h0);
         issueReq(1'b0, 1'b1, holes[i], 32'h0, 4'h0, 1'b1, 32'h0);
      end
      loadData(`DMEM_BASE);
      crLoad(`CR_LED);
      crLoad(`CR_SCRATCH);
      repeat (3) idleCycle();

      $display("STATUS: PASS");
      $finish;
   end

endmodule

// ==== memWrap.f ====
+incdir+include
design/memWrapPkg.sv
design/dataMem.sv
design/crMem.sv
design/memWrap.sv
bench/memWrapTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the memWrap testbench with Verilator
# Exit status is zero only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=memWrapSim

# Build the simulation binary from the file list
verilator --binary --timing --assert \
   -f memWrap.f \
   --top-module memWrapTb \
   -Mdir "$BUILD_DIR" \
   -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "run.sh: Verilator compile failed"
   exit 1
fi

# Run and keep the output for the pass search
"$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
   echo "run.sh: simulation exited with status $simStatus"
   exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG_FILE"; then
   exit 0
fi
echo "run.sh: pass line not found in $LOG_FILE"
exit 1
